//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_rv_ex_core
FILELIST  = vlog.f
PASS_TEXT = TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run, fails unless the pass line appears"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

    // One data word for operands, results and immediates
    typedef logic [31:0] xlen_t;

    // Architectural register index, x0 is hardwired to zero
    typedef logic [4:0] reg_idx_t;

    // Decoded micro-ops accepted on the issue port
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLT,
        OP_ADDI,
        OP_DIVU,
        OP_REMU,
        OP_LW,
        OP_SW
    } op_e;

    // Where the value written back for an op in MEM comes from
    // Divider results use RES_ALU because they are complete when they leave EX
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_NONE
    } res_src_e;

    // Data memory is word addressed by byte address bits 7 to 2
    localparam int DMEM_WORDS = 64;
    typedef logic [5:0] dmem_addr_t;

    // The restoring divider produces one quotient bit per step
    localparam int DIV_STEPS = 32;
    typedef logic [5:0] div_cnt_t;

endpackage

//--- rtl/rv_div.sv
`timescale 1ns/1ns

module rv_div import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  xlen_t dividend,
    input  xlen_t divisor,
    input  logic  is_rem,
    output xlen_t captured_a,
    output xlen_t captured_b,
    output logic  done,
    output xlen_t result
);

    logic        busy;
    div_cnt_t    cnt;
    logic        rem_sel;
    xlen_t       quo_q;
    xlen_t       rem_q;
    xlen_t       step_q;
    xlen_t       step_r;
    xlen_t       step_d;
    logic [32:0] shifted;
    xlen_t       quo_nxt;
    xlen_t       rem_nxt;

    // The first step runs straight off the inputs in the start cycle
    assign step_q = start ? dividend : quo_q;
    assign step_r = start ? '0 : rem_q;
    assign step_d = start ? divisor : captured_b;

    // Restoring step: shift in the next dividend bit and subtract when it fits
    // A zero divisor always fits, which leaves all ones and the dividend as remainder
    always_comb begin
        shifted = {step_r, step_q[31]};
        if (shifted >= {1'b0, step_d}) begin
            rem_nxt = xlen_t'(shifted - {1'b0, step_d});
            quo_nxt = {step_q[30:0], 1'b1};
        end else begin
            rem_nxt = shifted[31:0];
            quo_nxt = {step_q[30:0], 1'b0};
        end
    end

    // cnt counts finished steps and done follows the last one
    assign done   = busy && cnt == div_cnt_t'(DIV_STEPS);
    assign result = rem_sel ? rem_q : quo_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= div_cnt_t'(1);
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end
    end

    // Operands are held for the forwarding unit until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            captured_a <= dividend;
            captured_b <= divisor;
            rem_sel    <= is_rem;
        end
        if (start || (busy && !done)) begin
            quo_q <= quo_nxt;
            rem_q <= rem_nxt;
        end
    end

endmodule

//--- rtl/rv_ex_core.sv
`timescale 1ns/1ns

module rv_ex_core import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     issue_valid,
    input  op_e      issue_op,
    input  reg_idx_t issue_rs1,
    input  reg_idx_t issue_rs2,
    input  reg_idx_t issue_rd,
    input  xlen_t    issue_imm,
    output logic     issue_ready,
    output logic     retire_valid,
    output reg_idx_t retire_rd,
    output xlen_t    retire_data
);

    op_e      ex_op;
    logic     id_ex_load;
    logic     div_start;
    logic     div_done;
    logic     mc_in_progress;
    xlen_t    rf_rd1;
    xlen_t    rf_rd2;
    xlen_t    load_data_mem;
    logic     rf_we;
    reg_idx_t rf_wa;
    xlen_t    rf_wd;

    rv_ex_mem_if ex_mem ();

    rv_pipe_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_rd       (issue_rd),
        .div_done       (div_done),
        .issue_ready    (issue_ready),
        .ex_op          (ex_op),
        .id_ex_load     (id_ex_load),
        .div_start      (div_start),
        .mc_in_progress (mc_in_progress),
        .ex_mem         (ex_mem.ctrl_src)
    );

    // Operands are read at issue, with the MEM write bypassed in
    rv_regfile u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (issue_rs1),
        .rs2   (issue_rs2),
        .we    (rf_we),
        .wa    (rf_wa),
        .wd    (rf_wd),
        .rd1   (rf_rd1),
        .rd2   (rf_rd2)
    );

    rv_ex_datapath u_ex (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_ex_load     (id_ex_load),
        .rf_rd1         (rf_rd1),
        .rf_rd2         (rf_rd2),
        .issue_imm      (issue_imm),
        .issue_rs1      (issue_rs1),
        .issue_rs2      (issue_rs2),
        .ex_op          (ex_op),
        .div_start      (div_start),
        .mc_in_progress (mc_in_progress),
        .load_data_mem  (load_data_mem),
        .div_done       (div_done),
        .ex_mem         (ex_mem.data_src),
        .ex_mem_fwd     (ex_mem.fwd)
    );

    rv_mem_stage u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_mem        (ex_mem.mem),
        .load_data_mem (load_data_mem),
        .rf_we         (rf_we),
        .rf_wa         (rf_wa),
        .rf_wd         (rf_wd),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data)
    );

endmodule

//--- rtl/rv_ex_datapath.sv
`timescale 1ns/1ns

module rv_ex_datapath import rv_core_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          id_ex_load,
    input  xlen_t         rf_rd1,
    input  xlen_t         rf_rd2,
    input  xlen_t         issue_imm,
    input  reg_idx_t      issue_rs1,
    input  reg_idx_t      issue_rs2,
    input  op_e           ex_op,
    input  logic          div_start,
    input  logic          mc_in_progress,
    input  xlen_t         load_data_mem,
    output logic          div_done,
    rv_ex_mem_if.data_src ex_mem,
    rv_ex_mem_if.fwd      ex_mem_fwd
);

    reg_idx_t rs1_ex;
    reg_idx_t rs2_ex;
    xlen_t    rs1_data_ex;
    xlen_t    rs2_data_ex;
    xlen_t    imm_ex;
    xlen_t    fwd_rs1_ex;
    xlen_t    fwd_rs2_ex;
    xlen_t    div_cap_a;
    xlen_t    div_cap_b;
    xlen_t    div_result;
    xlen_t    alu_result;
    logic     ex_is_div;

    // Indices start at x0 so nothing can match a stale MEM entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rs1_ex <= '0;
            rs2_ex <= '0;
        end else if (id_ex_load) begin
            rs1_ex <= issue_rs1;
            rs2_ex <= issue_rs2;
        end
    end

    always_ff @(posedge clk) begin
        if (id_ex_load) begin
            rs1_data_ex <= rf_rd1;
            rs2_data_ex <= rf_rd2;
            imm_ex      <= issue_imm;
        end
    end

    rv_fwd_ex u_fwd (
        .rs1_ex          (rs1_ex),
        .rs2_ex          (rs2_ex),
        .rs1_data_ex     (rs1_data_ex),
        .rs2_data_ex     (rs2_data_ex),
        .mc_in_progress  (mc_in_progress),
        .mc_rs1_captured (div_cap_a),
        .mc_rs2_captured (div_cap_b),
        .load_data_mem   (load_data_mem),
        .ex_mem          (ex_mem_fwd),
        .fwd_rs1_ex      (fwd_rs1_ex),
        .fwd_rs2_ex      (fwd_rs2_ex)
    );

    assign ex_is_div = (ex_op == OP_DIVU || ex_op == OP_REMU);

    rv_div u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (div_start),
        .dividend   (fwd_rs1_ex),
        .divisor    (fwd_rs2_ex),
        .is_rem     (ex_op == OP_REMU),
        .captured_a (div_cap_a),
        .captured_b (div_cap_b),
        .done       (div_done),
        .result     (div_result)
    );

    // Loads and stores use the ALU to form rs1 plus the immediate
    always_comb begin
        case (ex_op)
            OP_ADD:  alu_result = fwd_rs1_ex + fwd_rs2_ex;
            OP_SUB:  alu_result = fwd_rs1_ex - fwd_rs2_ex;
            OP_AND:  alu_result = fwd_rs1_ex & fwd_rs2_ex;
            OP_OR:   alu_result = fwd_rs1_ex | fwd_rs2_ex;
            OP_XOR:  alu_result = fwd_rs1_ex ^ fwd_rs2_ex;
            OP_SLL:  alu_result = fwd_rs1_ex << fwd_rs2_ex[4:0];
            OP_SRL:  alu_result = fwd_rs1_ex >> fwd_rs2_ex[4:0];
            OP_SLT:  alu_result = xlen_t'($signed(fwd_rs1_ex) < $signed(fwd_rs2_ex));
            OP_ADDI: alu_result = fwd_rs1_ex + imm_ex;
            OP_LW:   alu_result = fwd_rs1_ex + imm_ex;
            OP_SW:   alu_result = fwd_rs1_ex + imm_ex;
            // Divides take the divider output instead
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_mem.result     <= ex_is_div ? div_result : alu_result;
        ex_mem.store_data <= fwd_rs2_ex;
    end

endmodule

//--- rtl/rv_ex_mem_if.sv
`timescale 1ns/1ns

// EX/MEM pipeline register, split between a control half and a data half
interface rv_ex_mem_if import rv_core_pkg::*;;

    logic     valid;
    reg_idx_t rd;
    logic     reg_write;
    res_src_e res_src;
    xlen_t    result;
    xlen_t    store_data;

    // Control fields come from the pipe controller
    modport ctrl_src (output valid, rd, reg_write, res_src);

    // Result and store data come from the EX datapath
    modport data_src (output result, store_data);

    // MEM stage consumes the whole register
    modport mem (input valid, rd, reg_write, res_src, result, store_data);

    // Forwarding only needs the producer side, store data never forwards
    modport fwd (input valid, rd, reg_write, res_src, result);

endinterface

//--- rtl/rv_fwd_ex.sv
`timescale 1ns/1ns

module rv_fwd_ex import rv_core_pkg::*; (
    input  reg_idx_t     rs1_ex,
    input  reg_idx_t     rs2_ex,
    input  xlen_t        rs1_data_ex,
    input  xlen_t        rs2_data_ex,
    input  logic         mc_in_progress,
    input  xlen_t        mc_rs1_captured,
    input  xlen_t        mc_rs2_captured,
    input  xlen_t        load_data_mem,
    rv_ex_mem_if.fwd     ex_mem,
    output xlen_t        fwd_rs1_ex,
    output xlen_t        fwd_rs2_ex
);

    logic mem_fwd_ok;
    logic mem_is_load;
    logic hit_rs1;
    logic hit_rs2;

    // Producer in MEM must be live and write a real register
    assign mem_fwd_ok  = ex_mem.valid && ex_mem.reg_write && ex_mem.rd != '0;
    // Memory reads combinationally, so load data is already usable in MEM
    assign mem_is_load = (ex_mem.res_src == RES_MEM);
    assign hit_rs1     = mem_fwd_ok && ex_mem.rd == rs1_ex;
    assign hit_rs2     = mem_fwd_ok && ex_mem.rd == rs2_ex;

    // Priority is captured divider operand, then MEM load, then MEM result
    // During a divide MEM holds unrelated ops, so only the captured values are valid
    function automatic xlen_t fwd_pick(
        input logic  use_mc,
        input logic  hit_mem,
        input logic  from_load,
        input xlen_t mc_val,
        input xlen_t load_val,
        input xlen_t res_val,
        input xlen_t rf_val
    );
        if (use_mc) begin
            return mc_val;
        end else if (hit_mem && from_load) begin
            return load_val;
        end else if (hit_mem) begin
            return res_val;
        end
        return rf_val;
    endfunction

    assign fwd_rs1_ex = fwd_pick(mc_in_progress, hit_rs1, mem_is_load, mc_rs1_captured,
                                 load_data_mem, ex_mem.result, rs1_data_ex);
    assign fwd_rs2_ex = fwd_pick(mc_in_progress, hit_rs2, mem_is_load, mc_rs2_captured,
                                 load_data_mem, ex_mem.result, rs2_data_ex);

endmodule

//--- rtl/rv_mem_stage.sv
`timescale 1ns/1ns

module rv_mem_stage import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    rv_ex_mem_if.mem        ex_mem,
    output xlen_t           load_data_mem,
    output logic            rf_we,
    output reg_idx_t        rf_wa,
    output xlen_t           rf_wd,
    output logic            retire_valid,
    output reg_idx_t        retire_rd,
    output xlen_t           retire_data
);

    xlen_t      dmem [DMEM_WORDS];
    dmem_addr_t addr;
    logic       store_en;

    // Word index from the address computed in EX
    assign addr     = ex_mem.result[7:2];
    assign store_en = ex_mem.valid && ex_mem.res_src == RES_NONE;

    // SRAM style read, so load data is ready within MEM
    assign load_data_mem = dmem[addr];

    // Register file takes the write on the edge that closes MEM
    assign rf_we = ex_mem.valid && ex_mem.reg_write;
    assign rf_wa = ex_mem.rd;
    assign rf_wd = (ex_mem.res_src == RES_MEM) ? load_data_mem : ex_mem.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_en) begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    // Writes to x0 are dropped, so they never retire
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= rf_we && rf_wa != '0;
        end
    end

    always_ff @(posedge clk) begin
        retire_rd   <= rf_wa;
        retire_data <= rf_wd;
    end

endmodule

//--- rtl/rv_pipe_ctrl.sv
`timescale 1ns/1ns

module rv_pipe_ctrl import rv_core_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          issue_valid,
    input  op_e           issue_op,
    input  reg_idx_t      issue_rd,
    input  logic          div_done,
    output logic          issue_ready,
    output op_e           ex_op,
    output logic          id_ex_load,
    output logic          div_start,
    output logic          mc_in_progress,
    rv_ex_mem_if.ctrl_src ex_mem
);

    logic     ex_valid;
    reg_idx_t ex_rd;
    logic     ex_is_div;
    logic     ex_stall;

    assign ex_is_div = ex_valid && (ex_op == OP_DIVU || ex_op == OP_REMU);

    // A divide holds EX until the divider reports done
    assign ex_stall    = ex_is_div && !div_done;
    assign issue_ready = !ex_stall;
    assign id_ex_load  = issue_valid && issue_ready;

    // First EX cycle of a divide launches the divider
    assign div_start = ex_is_div && !mc_in_progress;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid       <= 1'b0;
            mc_in_progress <= 1'b0;
        end else begin
            // No issue while EX is free gives a bubble
            if (!ex_stall) begin
                ex_valid <= issue_valid;
            end
            if (div_done) begin
                mc_in_progress <= 1'b0;
            end else if (div_start) begin
                mc_in_progress <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_stall) begin
            ex_op <= issue_op;
            ex_rd <= issue_rd;
        end
    end

    // An unfinished divide sends bubbles into MEM so the pipe drains
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= ex_valid && !ex_stall;
        end
    end

    // Stores are the only ops without a destination register
    always_ff @(posedge clk) begin
        ex_mem.rd        <= ex_rd;
        ex_mem.reg_write <= (ex_op != OP_SW);
        case (ex_op)
            OP_LW:   ex_mem.res_src <= RES_MEM;
            OP_SW:   ex_mem.res_src <= RES_NONE;
            default: ex_mem.res_src <= RES_ALU;
        endcase
    end

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     we,
    input  reg_idx_t wa,
    input  xlen_t    wd,
    output xlen_t    rd1,
    output xlen_t    rd2
);

    xlen_t regs [32];

    // A write landing on this edge is passed straight to the read port
    // This bypass stands in for WB to ID forwarding and keeps it off the EX path
    function automatic xlen_t read_port(
        input reg_idx_t ra,
        input xlen_t    stored,
        input logic     w_en,
        input reg_idx_t w_addr,
        input xlen_t    w_data
    );
        if (ra == '0) begin
            return '0;
        end else if (w_en && w_addr == ra) begin
            return w_data;
        end
        return stored;
    endfunction

    assign rd1 = read_port(rs1, regs[rs1], we, wa, wd);
    assign rd2 = read_port(rs2, regs[rs2], we, wa, wd);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

endmodule

//--- sim/tb_rv_ex_core.sv
`timescale 1ns/1ns

module tb_rv_ex_core import rv_core_pkg::*;;

    // About 290 issued ops and roughly 45 divides of DIV_STEPS+1 cycles each plus the drains
    localparam int MAX_CYCLES = 3000;

    logic     clk;
    logic     rst_n;
    logic     issue_valid;
    op_e      issue_op;
    reg_idx_t issue_rs1;
    reg_idx_t issue_rs2;
    reg_idx_t issue_rd;
    xlen_t    issue_imm;
    logic     issue_ready;
    logic     retire_valid;
    reg_idx_t retire_rd;
    xlen_t    retire_data;

    // Reference state is updated in issue order
    xlen_t    model_regs [32];
    xlen_t    model_mem [DMEM_WORDS];
    reg_idx_t exp_rd_q [$];
    xlen_t    exp_data_q [$];
    reg_idx_t exp_rd;
    xlen_t    exp_data;
    string    test_name;
    int       cycle_count;
    int       seed;
    // Set when the op just issued was a divide
    logic     after_div;

    rv_ex_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rd     (issue_rd),
        .issue_imm    (issue_imm),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("CHECK FAILED %s: %s expected %h actual %h",
                                        test_name, what, expected, actual));
        end
    endtask

    // Expected value of an op from the ISA rules
    // Loads and stores give their address here
    function automatic xlen_t ref_result(input op_e op, input xlen_t a, input xlen_t b,
                                         input xlen_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SLT:  return (signed'(a) < signed'(b)) ? 32'd1 : 32'd0;
            // Unsigned divide by zero gives all ones and the remainder keeps the dividend
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REMU: return (b == '0) ? a : a % b;
            default: return a + imm;
        endcase
    endfunction

    // Updates the model and then holds the op on the issue port until the DUT takes it
    task automatic send_op(input op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                           input reg_idx_t rs2, input xlen_t imm);
        xlen_t a;
        xlen_t b;
        xlen_t res;
        logic  ready;
        int    stalls;
        a   = model_regs[rs1];
        b   = model_regs[rs2];
        res = ref_result(op, a, b, imm);
        if (op == OP_SW) begin
            model_mem[res[7:2]] = b;
        end else begin
            if (op == OP_LW) begin
                res = model_mem[res[7:2]];
            end
            // x0 writes are dropped and never retire
            if (rd != '0) begin
                model_regs[rd] = res;
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(res);
            end
        end
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_rd    <= rd;
        issue_rs1   <= rs1;
        issue_rs2   <= rs2;
        issue_imm   <= imm;
        ready  = 1'b0;
        stalls = 0;
        while (!ready) begin
            @(negedge clk);
            ready = issue_ready;
            if (!ready) begin
                stalls++;
            end
            @(posedge clk);
        end
        // A divide sits in EX for DIV_STEPS+1 cycles and only the last one lets the next op in
        check_value("issue stall cycles", xlen_t'(after_div ? DIV_STEPS : 0), xlen_t'(stalls));
        after_div = (op == OP_DIVU || op == OP_REMU);
    endtask

    // Stops issuing and waits for every expected write to retire
    task automatic drain();
        issue_valid <= 1'b0;
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
        end
        after_div = 1'b0;
    endtask

    task automatic alu_basics();
        test_name = "alu basics";
        send_op(OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd100);
        send_op(OP_ADDI, 5'd2, 5'd0, 5'd0, 32'hffff_fff9);
        send_op(OP_ADDI, 5'd3, 5'd0, 5'd0, 32'd3);
        send_op(OP_ADDI, 5'd4, 5'd0, 5'd0, 32'h0000_5a5a);
        send_op(OP_ADD,  5'd5, 5'd1, 5'd2, '0);
        send_op(OP_SUB,  5'd6, 5'd1, 5'd2, '0);
        send_op(OP_AND,  5'd7, 5'd4, 5'd2, '0);
        send_op(OP_OR,   5'd8, 5'd4, 5'd1, '0);
        send_op(OP_XOR,  5'd9, 5'd4, 5'd2, '0);
        send_op(OP_SLL,  5'd10, 5'd4, 5'd3, '0);
        send_op(OP_SRL,  5'd11, 5'd2, 5'd3, '0);
        // SLT both ways round since x2 is negative
        send_op(OP_SLT,  5'd12, 5'd2, 5'd1, '0);
        send_op(OP_SLT,  5'd13, 5'd1, 5'd2, '0);
        send_op(OP_ADDI, 5'd14, 5'd4, 5'd0, 32'hffff_ffff);
        drain();
    endtask

    task automatic forwarding_chains();
        reg_idx_t prev;
        reg_idx_t nxt;
        test_name = "forwarding";
        // Fillers set the producer to consumer distance
        // Distance 1 forwards from MEM and distance 2 reads through the regfile bypass
        for (int d = 1; d <= 3; d++) begin
            prev = 5'd15;
            send_op(OP_ADDI, prev, 5'd0, 5'd0, 32'h101 * d);
            for (int k = 0; k < 6; k++) begin
                nxt = (prev == 5'd15) ? 5'd16 : 5'd15;
                for (int f = 1; f < d; f++) begin
                    send_op(OP_ADDI, 5'd20, 5'd20, 5'd0, 32'd3);
                end
                case (k % 3)
                    0:       send_op(OP_ADD, nxt, prev, 5'd4, '0);
                    1:       send_op(OP_SUB, nxt, 5'd1, prev, '0);
                    default: send_op(OP_ADD, nxt, prev, prev, '0);
                endcase
                prev = nxt;
            end
        end
        drain();
    endtask

    task automatic load_store_pairs();
        test_name = "load store";
        send_op(OP_ADDI, 5'd21, 5'd0, 5'd0, 32'h40);
        send_op(OP_ADDI, 5'd22, 5'd0, 5'd0, 32'h123);
        // Store then load of the same word back to back
        send_op(OP_SW,   5'd0,  5'd21, 5'd22, 32'd0);
        send_op(OP_LW,   5'd23, 5'd21, 5'd0,  32'd0);
        send_op(OP_ADD,  5'd24, 5'd23, 5'd22, '0);
        // Store data taken from an ALU result and then from a load in MEM
        send_op(OP_SW,   5'd0,  5'd21, 5'd24, 32'd4);
        send_op(OP_LW,   5'd25, 5'd21, 5'd0,  32'd4);
        send_op(OP_SW,   5'd0,  5'd21, 5'd25, 32'd8);
        send_op(OP_LW,   5'd26, 5'd21, 5'd0,  32'd8);
        // Address base from the load just before
        send_op(OP_LW,   5'd27, 5'd26, 5'd0,  32'd0);
        send_op(OP_SUB,  5'd28, 5'd27, 5'd26, '0);
        send_op(OP_LW,   5'd29, 5'd21, 5'd0,  32'd60);
        drain();
    endtask

    task automatic divide_cases();
        test_name = "divide";
        // Every divide is followed right away by an op that reads its result
        send_op(OP_ADDI, 5'd5,  5'd0,  5'd0, 32'd1000);
        send_op(OP_ADDI, 5'd6,  5'd0,  5'd0, 32'd7);
        send_op(OP_DIVU, 5'd7,  5'd5,  5'd6, '0);
        send_op(OP_ADD,  5'd8,  5'd7,  5'd6, '0);
        send_op(OP_REMU, 5'd9,  5'd5,  5'd6, '0);
        send_op(OP_SUB,  5'd10, 5'd9,  5'd5, '0);
        send_op(OP_DIVU, 5'd11, 5'd5,  5'd0, '0);
        send_op(OP_XOR,  5'd18, 5'd11, 5'd5, '0);
        send_op(OP_REMU, 5'd12, 5'd5,  5'd0, '0);
        send_op(OP_ADDI, 5'd13, 5'd12, 5'd0, 32'd1);
        send_op(OP_ADDI, 5'd14, 5'd0,  5'd0, 32'hffff_ffff);
        // Back to back divides where the second one eats the first result
        send_op(OP_DIVU, 5'd15, 5'd14, 5'd6,  '0);
        send_op(OP_REMU, 5'd16, 5'd15, 5'd14, '0);
        send_op(OP_SUB,  5'd18, 5'd16, 5'd6,  '0);
        // Dividend straight from a load in MEM
        send_op(OP_LW,   5'd30, 5'd21, 5'd0,  32'd0);
        send_op(OP_DIVU, 5'd31, 5'd30, 5'd6,  '0);
        send_op(OP_OR,   5'd17, 5'd31, 5'd30, '0);
        drain();
    endtask

    task automatic x0_writes();
        test_name = "x0 handling";
        send_op(OP_ADDI, 5'd0,  5'd0,  5'd0, 32'd55);
        // Must not pick up the x0 write from MEM
        send_op(OP_ADD,  5'd17, 5'd0,  5'd0, '0);
        send_op(OP_ADD,  5'd0,  5'd1,  5'd2, '0);
        send_op(OP_OR,   5'd18, 5'd0,  5'd1, '0);
        send_op(OP_LW,   5'd0,  5'd21, 5'd0, 32'd0);
        send_op(OP_ADDI, 5'd19, 5'd0,  5'd0, 32'd9);
        send_op(OP_DIVU, 5'd0,  5'd5,  5'd6, '0);
        send_op(OP_SUB,  5'd17, 5'd19, 5'd0, '0);
        drain();
    endtask

    task automatic random_mix();
        int       r;
        int       k;
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        test_name = "random mix";
        // x1 is the memory base and is never a random destination
        send_op(OP_ADDI, 5'd1, 5'd0, 5'd0, 32'h100);
        for (int n = 0; n < 200; n++) begin
            k   = {$random(seed)} % 13;
            r   = $random(seed);
            op  = op_e'(k[3:0]);
            rd  = r[4:0];
            rs1 = r[9:5];
            rs2 = r[14:10];
            imm = {{20{r[31]}}, r[31:20]};
            if (rd == 5'd1) begin
                rd = 5'd0;
            end
            if (op == OP_LW || op == OP_SW) begin
                rs1 = 5'd1;
                imm = {24'd0, r[20:15], 2'b00};
            end
            send_op(op, rd, rs1, rs2, imm);
        end
        drain();
    endtask

    // Retire outputs are registered and settled by the falling edge
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            if (exp_rd_q.size() == 0) begin
                stop_with_failure($sformatf("%s: retire of x%0d with no write outstanding",
                                            test_name, retire_rd));
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                check_value("retire rd", xlen_t'(exp_rd), xlen_t'(retire_rd));
                check_value("retire data", exp_data, retire_data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            stop_with_failure($sformatf("%s: no progress after %0d cycles, run stopped",
                                        test_name, MAX_CYCLES));
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_ADD;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_rd    = '0;
        issue_imm   = '0;
        cycle_count = 0;
        seed        = 98;
        after_div   = 1'b0;
        test_name   = "reset";
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        // The pipe comes out of reset empty and ready to accept an op
        @(negedge clk);
        check_value("issue ready", 32'd1, xlen_t'(issue_ready));
        check_value("retire valid", 32'd0, xlen_t'(retire_valid));
        @(posedge clk);
        rst_n <= 1'b1;
        alu_basics();
        forwarding_chains();
        load_store_pairs();
        divide_cases();
        x0_writes();
        random_mix();
        // A few idle cycles catch stray retires
        repeat (8) @(posedge clk);
        if (exp_rd_q.size() != 0) begin
            stop_with_failure($sformatf("%0d register writes never retired", exp_rd_q.size()));
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- vlog.f
rtl/rv_core_pkg.sv
rtl/rv_ex_mem_if.sv
rtl/rv_regfile.sv
rtl/rv_fwd_ex.sv
rtl/rv_div.sv
rtl/rv_ex_datapath.sv
rtl/rv_pipe_ctrl.sv
rtl/rv_mem_stage.sv
rtl/rv_ex_core.sv
sim/tb_rv_ex_core.sv
